/* logic/mm_pkg.sv */
package mm_pkg;

	// ------------------------------------------------------------
	// register map
	// ------------------------------------------------------------
	typedef enum logic [5:0] {
		PWMC = 6'h02, // pwm duty
		WDG  = 6'h03, // watchdog enable and count
		SFT  = 6'h04, // shift driver a
		FAN0 = 6'h05,
		FAN1 = 6'h06,
		TIME = 6'h07, // second timers
		GPIO = 6'h08,
		SFTB = 6'h09, // shift driver b
		CLKO = 6'h0a  // clock out enable
	} mm_addr_e;

	// 74HC595 command set
	typedef enum logic [1:0] {
		SFT_MR    = 2'b00, // master reset pulse
		SFT_SHIFT = 2'b01, // shift out one byte
		SFT_STORE = 2'b10, // storage latch pulse
		SFT_OE    = 2'b11  // output enable level
	} sft_op_e;

	typedef struct packed {
		logic       valid;
		sft_op_e    op;
		logic       oen;  // level for SFT_OE
		logic [7:0] data; // byte for SFT_SHIFT
	} sft_cmd_t;

	typedef struct packed {
		logic shcp;
		logic ds;
		logic stcp;
		logic mr_n;
		logic oe_n;
	} sft_pins_t;

	// ------------------------------------------------------------
	// timing and widths
	// ------------------------------------------------------------
	localparam int SFT_HALF  = 2;   // half shcp period
	localparam int SFT_PULSE = 4;   // mr_n low / stcp high
	localparam int SFT_PH_W  = $clog2((2 * SFT_HALF > SFT_PULSE) ? 2 * SFT_HALF : SFT_PULSE);

	localparam int TICK_CYCLES = 400; // one "second", short for sim
	localparam int TICK_W      = $clog2(TICK_CYCLES);

	localparam int PWM_W = 10;
	localparam int WDG_W = 26;
	localparam int FAN_W = 27;

	localparam logic [15:0] GPIO_RST = 16'h8800;

endpackage

/* logic/sft_drv.sv */
`timescale 1ns/1ps

module sft_drv (
	input  logic              CLK_I,
	input  logic              RST_I,
	input  mm_pkg::sft_cmd_t  cmd,
	output logic              done,
	output logic              idle,
	output mm_pkg::sft_pins_t pins
);
	import mm_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		SHIFT,
		MR,
		STORE,
		OE
	} state_e;

	state_e              state;
	logic [SFT_PH_W-1:0] phase;
	logic [2:0]          bit_cnt;
	logic [7:0]          sreg;     // bits still to go out, msb first
	sft_pins_t           pins_q;
	logic                bit_last; // last cycle of one bit
	logic                pulse_last;

	assign bit_last   = (phase == SFT_PH_W'(2 * SFT_HALF - 1));
	assign pulse_last = (phase == SFT_PH_W'(SFT_PULSE - 1));
	assign idle       = (state == IDLE);
	assign pins       = pins_q;

	// ------------------------------------------------------------
	// command sequencer
	// ------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			state   <= IDLE;
			phase   <= '0;
			bit_cnt <= '0;
			pins_q  <= '{shcp: 1'b0, ds: 1'b0, stcp: 1'b0, mr_n: 1'b1, oe_n: 1'b1};
		end else begin
			case (state)
				IDLE: begin
					// busy writes never get here, so they are lost
					if (cmd.valid) begin
						phase <= '0;
						case (cmd.op)
							SFT_SHIFT: begin
								state     <= SHIFT;
								bit_cnt   <= 3'd7;
								pins_q.ds <= cmd.data[7];
							end
							SFT_MR: begin
								state       <= MR;
								pins_q.mr_n <= 1'b0;
							end
							SFT_STORE: begin
								state       <= STORE;
								pins_q.stcp <= 1'b1;
							end
							default: begin
								state       <= OE;
								pins_q.oe_n <= cmd.oen;
							end
						endcase
					end
				end
				SHIFT: begin
					if (bit_last) begin
						phase       <= '0;
						pins_q.shcp <= 1'b0;
						if (bit_cnt == 3'd0) begin
							state     <= IDLE;
							pins_q.ds <= 1'b0;
						end else begin
							bit_cnt   <= bit_cnt - 1'b1;
							pins_q.ds <= sreg[6];
						end
					end else begin
						phase <= phase + 1'b1;
						if (phase == SFT_PH_W'(SFT_HALF - 1))
							pins_q.shcp <= 1'b1; // rising edge mid bit
					end
				end
				MR: begin
					if (pulse_last) begin
						state       <= IDLE;
						pins_q.mr_n <= 1'b1;
					end else begin
						phase <= phase + 1'b1;
					end
				end
				STORE: begin
					if (pulse_last) begin
						state       <= IDLE;
						pins_q.stcp <= 1'b0;
					end else begin
						phase <= phase + 1'b1;
					end
				end
				OE:      state <= IDLE; // level already applied
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_I) begin
		if (idle && cmd.valid)
			sreg <= cmd.data;
		else if ((state == SHIFT) && bit_last && (bit_cnt != 3'd0))
			sreg <= {sreg[6:0], 1'b0};
	end

	// done marks the final cycle of each command
	always_comb begin
		case (state)
			SHIFT:     done = bit_last && (bit_cnt == 3'd0);
			MR, STORE: done = pulse_last;
			OE:        done = 1'b1;
			default:   done = 1'b0;
		endcase
	end

	a_mr_stcp_excl: assert property (@(posedge CLK_I) disable iff (RST_I)
		!(!pins_q.mr_n && pins_q.stcp));
	a_done_busy: assert property (@(posedge CLK_I) disable iff (RST_I)
		done |-> !idle ##1 idle);

endmodule

/* logic/fan_tach.sv */
`timescale 1ns/1ps

module fan_tach (
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic [1:0]  fan_in,
	output logic [26:0] count0,
	output logic [26:0] count1
);
	import mm_pkg::*;

	logic [TICK_W-1:0] win_cnt;
	logic              win_end;

	// ------------------------------------------------------------
	// measurement window
	// ------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			win_cnt <= '0;
		else if (win_end)
			win_cnt <= '0;
		else
			win_cnt <= win_cnt + 1'b1;
	end

	assign win_end = (win_cnt == TICK_W'(TICK_CYCLES - 1));

	// one channel per tach input
	for (genvar i = 0; i < 2; i++) begin : g_ch
		logic [2:0]       sync; // [1:0] synchronizer, [2] edge history
		logic [FAN_W-1:0] cnt;
		logic [FAN_W-1:0] latched;
		logic             fall;

		assign fall = sync[2] && !sync[1];

		always_ff @(posedge CLK_I or posedge RST_I) begin
			if (RST_I) begin
				sync    <= '0;
				cnt     <= '0;
				latched <= '0;
			end else begin
				sync <= {sync[1:0], fan_in[i]};
				if (win_end) begin
					latched <= cnt; // edge on this cycle is dropped
					cnt     <= '0;
				end else if (fall) begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	assign count0 = g_ch[0].latched;
	assign count1 = g_ch[1].latched;

endmodule

/* logic/sec_timer.sv */
`timescale 1ns/1ps

module sec_timer (
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic        wr,
	input  logic [31:0] dat,
	output logic [31:0] status,
	output logic        int0,
	output logic        int1
);
	import mm_pkg::*;

	logic [TICK_W-1:0] tick_cnt;
	logic              tick;

	// ------------------------------------------------------------
	// one second timebase
	// ------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	// ------------------------------------------------------------
	// timer channels, fields of channel i start at bit 16*i
	// ------------------------------------------------------------
	for (genvar i = 0; i < 2; i++) begin : g_tim
		logic [5:0]  cnt;
		logic        done;
		logic        mask;
		logic        load;
		logic [15:0] word;
		logic        irq;

		assign load = wr && dat[16*i];

		always_ff @(posedge CLK_I or posedge RST_I) begin
			if (RST_I) begin
				cnt  <= '0;
				done <= 1'b0;
				mask <= 1'b1; // masked until software opens it
			end else begin
				if (wr)
					mask <= dat[16*i+1];
				if (load)
					cnt <= dat[16*i+2 +: 6];
				else if (tick && (cnt != 6'd0))
					cnt <= cnt - 1'b1;
				// expiry wins over a clear in the same cycle
				if (tick && (cnt == 6'd1) && !load)
					done <= 1'b1;
				else if (wr && dat[16*i+8])
					done <= 1'b0;
			end
		end

		assign word = {7'b0, done, cnt, mask, 1'b0};
		assign irq  = done && !mask;
	end

	assign status = {g_tim[1].word, g_tim[0].word};
	assign int0   = g_tim[0].irq;
	assign int1   = g_tim[1].irq;

	a_irq_done: assert property (@(posedge CLK_I) disable iff (RST_I)
		$rose(int0) |-> $past(g_tim[0].cnt) == 6'd1 || $past(g_tim[0].mask));

endmodule

/* logic/mm_regs.sv */
`timescale 1ns/1ps

module mm_regs (
	input  logic              CLK_I,
	input  logic              RST_I,
	// wishbone slave
	input  logic              stb,
	input  logic              we,
	input  mm_pkg::mm_addr_e  adr,
	input  logic [31:0]       dat_i,
	output logic              ack,
	output logic [31:0]       dat_o,
	// status from the peripherals
	input  logic [15:0]       gpio_in,
	input  logic [1:0]        sft_done,
	input  logic [26:0]       fan0,
	input  logic [26:0]       fan1,
	input  logic [31:0]       tim_status,
	input  logic [1:0]        sft_oe_n,
	// controls
	output logic              pwm,
	output logic              watch_dog,
	output logic [15:0]       gpio_out,
	output logic              clk25m_on,
	output mm_pkg::sft_cmd_t  sft_cmd_a,
	output mm_pkg::sft_cmd_t  sft_cmd_b,
	output logic              time_wr,
	output logic [31:0]       time_dat
);
	import mm_pkg::*;

	logic             wr_acc;
	logic             rd_acc;
	logic             wr_pwm;
	logic             wr_wdg;
	logic             wr_sft;
	logic             wr_sftb;
	logic             wr_gpio;
	logic             wr_clko;
	logic             rd_vld_q;
	mm_addr_e         rd_adr_q;
	logic [PWM_W-1:0] pwm_duty;
	logic [PWM_W-1:0] pwm_cnt;
	logic             wdg_en;
	logic [WDG_W-1:0] wdg_cnt;
	logic [15:0]      gpio_in_s1;
	logic [15:0]      gpio_in_q;
	logic [1:0]       done_q;   // sticky shift done, [0] = a

	// ------------------------------------------------------------
	// bus handshake and decode
	// ------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			ack <= 1'b0;
		else
			ack <= stb && !ack; // one cycle high, then one low
	end

	assign wr_acc  = stb && we && !ack;
	assign rd_acc  = stb && !we && !ack;
	assign wr_pwm  = wr_acc && (adr == PWMC);
	assign wr_wdg  = wr_acc && (adr == WDG);
	assign wr_sft  = wr_acc && (adr == SFT);
	assign wr_sftb = wr_acc && (adr == SFTB);
	assign wr_gpio = wr_acc && (adr == GPIO);
	assign wr_clko = wr_acc && (adr == CLKO);
	assign time_wr = wr_acc && (adr == TIME);
	assign time_dat = dat_i;

	// ------------------------------------------------------------
	// pwm
	// ------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			pwm_duty <= '0;
			pwm_cnt  <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1; // free running
			if (wr_pwm)
				pwm_duty <= dat_i[PWM_W-1:0];
		end
	end

	assign pwm = (pwm_cnt <= pwm_duty);

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			wdg_en  <= 1'b0;
			wdg_cnt <= '0;
		end else begin
			if (wr_wdg)
				wdg_en <= dat_i[0];
			if (wr_wdg && (wdg_en || dat_i[0]))
				wdg_cnt <= dat_i[WDG_W:1]; // reload postpones expiry
			else if (wdg_cnt != '0)
				wdg_cnt <= wdg_cnt - 1'b1;
		end
	end

	// two-cycle pulse just before expiry
	assign watch_dog = wdg_en && ((wdg_cnt == WDG_W'(2)) || (wdg_cnt == WDG_W'(1)));

	// ------------------------------------------------------------
	// gpio, clock enable
	// ------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			gpio_out  <= GPIO_RST;
			clk25m_on <= 1'b0;
		end else begin
			if (wr_gpio)
				gpio_out <= dat_i[15:0];
			if (wr_clko)
				clk25m_on <= dat_i[0];
		end
	end

	always_ff @(posedge CLK_I) begin
		gpio_in_s1 <= gpio_in;
		gpio_in_q  <= gpio_in_s1;
	end

	// ------------------------------------------------------------
	// shift driver commands
	// ------------------------------------------------------------
	assign sft_cmd_a = '{valid: wr_sft, op: sft_op_e'(dat_i[1:0]), oen: dat_i[2],
		data: dat_i[15:8]};
	assign sft_cmd_b = '{valid: wr_sftb, op: sft_op_e'(dat_i[1:0]), oen: dat_i[2],
		data: dat_i[15:8]};

	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I) begin
			done_q <= 2'b00;
		end else begin
			if (wr_sft)
				done_q[0] <= 1'b0;
			else if (sft_done[0])
				done_q[0] <= 1'b1;
			if (wr_sftb)
				done_q[1] <= 1'b0;
			else if (sft_done[1])
				done_q[1] <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// read path
	// ------------------------------------------------------------
	always_ff @(posedge CLK_I or posedge RST_I) begin
		if (RST_I)
			rd_vld_q <= 1'b0;
		else
			rd_vld_q <= rd_acc; // lines up with ack
	end

	always_ff @(posedge CLK_I) begin
		if (rd_acc)
			rd_adr_q <= adr;
	end

	always_comb begin
		dat_o = '0;
		if (rd_vld_q) begin
			case (rd_adr_q)
				PWMC:    dat_o = {{(32-PWM_W){1'b0}}, pwm_duty};
				WDG:     dat_o = {{(31-WDG_W){1'b0}}, wdg_cnt, wdg_en};
				SFT:     dat_o = {28'b0, done_q[0], sft_oe_n[0], 2'b0};
				SFTB:    dat_o = {28'b0, done_q[1], sft_oe_n[1], 2'b0};
				FAN0:    dat_o = {5'b0, fan0};
				FAN1:    dat_o = {5'b0, fan1};
				TIME:    dat_o = tim_status;
				GPIO:    dat_o = {gpio_in_q, gpio_out};
				CLKO:    dat_o = {31'b0, clk25m_on};
				default: dat_o = '0;
			endcase
		end
	end

	// read data only in a read ack, and ack never twice in a row
	a_ack_single: assert property (@(posedge CLK_I) disable iff (RST_I)
		ack |-> (rd_vld_q == !we) ##1 !ack);

endmodule

/* logic/mm_periph.sv */
`timescale 1ns/1ps

module mm_periph (
	input  logic              CLK_I,
	input  logic              RST_I,
	// wishbone slave
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [5:0]        wb_adr,
	input  logic [31:0]       wb_dat_i,
	output logic              wb_ack,
	output logic [31:0]       wb_dat_o,
	// board pins
	input  logic [1:0]        fan_in,
	input  logic [15:0]       gpio_in,
	output logic              pwm,
	output logic              watch_dog,
	output mm_pkg::sft_pins_t sft_a,
	output mm_pkg::sft_pins_t sft_b,
	output logic              time0_int,
	output logic              time1_int,
	output logic [15:0]       gpio_out,
	output logic              clk25m_on
);
	import mm_pkg::*;

	sft_cmd_t           cmd_a;
	sft_cmd_t           cmd_b;
	logic [1:0]         sft_done;
	logic [FAN_W-1:0]   fan0;
	logic [FAN_W-1:0]   fan1;
	logic               time_wr;
	logic [31:0]        time_dat;
	logic [31:0]        tim_status;

	// ------------------------------------------------------------
	// register file
	// ------------------------------------------------------------
	mm_regs i_mm_regs (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.stb        (wb_stb),
		.we         (wb_we),
		.adr        (mm_addr_e'(wb_adr)), // unmapped codes fall to default
		.dat_i      (wb_dat_i),
		.ack        (wb_ack),
		.dat_o      (wb_dat_o),
		.gpio_in    (gpio_in),
		.sft_done   (sft_done),
		.fan0       (fan0),
		.fan1       (fan1),
		.tim_status (tim_status),
		.sft_oe_n   ({sft_b.oe_n, sft_a.oe_n}),
		.pwm        (pwm),
		.watch_dog  (watch_dog),
		.gpio_out   (gpio_out),
		.clk25m_on  (clk25m_on),
		.sft_cmd_a  (cmd_a),
		.sft_cmd_b  (cmd_b),
		.time_wr    (time_wr),
		.time_dat   (time_dat)
	);

	// ------------------------------------------------------------
	// peripherals
	// ------------------------------------------------------------
	sft_drv i_sft_a (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.cmd   (cmd_a),
		.done  (sft_done[0]),
		.idle  (),
		.pins  (sft_a)
	);

	sft_drv i_sft_b (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.cmd   (cmd_b),
		.done  (sft_done[1]),
		.idle  (),
		.pins  (sft_b)
	);

	fan_tach i_fan_tach (
		.CLK_I  (CLK_I),
		.RST_I  (RST_I),
		.fan_in (fan_in),
		.count0 (fan0),
		.count1 (fan1)
	);

	sec_timer i_sec_timer (
		.CLK_I  (CLK_I),
		.RST_I  (RST_I),
		.wr     (time_wr),
		.dat    (time_dat),
		.status (tim_status),
		.int0   (time0_int),
		.int1   (time1_int)
	);

endmodule

/* dv/mm_vectors.svh */
`ifndef MM_VECTORS_SVH
`define MM_VECTORS_SVH

typedef enum logic [1:0] {
	OP_WR,   // bus write
	OP_RD,   // bus read, compare under mask
	OP_WAIT, // idle for data ticks
	OP_FAN   // fan edges, data = {m on fan1, n on fan0}
} vec_op_e;

typedef struct packed {
	vec_op_e     op;
	mm_addr_e    adr;
	logic [31:0] data;
	logic [31:0] exp;  // read value, on shift writes bit0 = accepted
	logic [31:0] mask;
	logic        rnd;  // take the random gpio values instead
} vec_t;

localparam int N_VECS = 34;

// columns: op, address, data, expected, mask, random
localparam vec_t VECS [N_VECS] = '{
	'{OP_RD,   GPIO, 32'h0000_0000, 32'h0000_8800, 32'h0000_ffff, 1'b0}, // reset value
	'{OP_WR,   GPIO, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
	'{OP_RD,   GPIO, 32'h0000_0000, 32'h0000_0000, 32'hffff_ffff, 1'b1},
	'{OP_WR,   CLKO, 32'h0000_0001, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_RD,   CLKO, 32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 1'b0},
	// driver a: shift, mr, store, oe
	'{OP_WR,   SFT,  32'h0000_a501, 32'h0000_0001, 32'h0000_0000, 1'b0},
	'{OP_WAIT, SFT,  32'd1,         32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_RD,   SFT,  32'h0000_0000, 32'h0000_000c, 32'h0000_000f, 1'b0},
	'{OP_WR,   SFT,  32'h0000_0000, 32'h0000_0001, 32'h0000_0000, 1'b0},
	'{OP_WAIT, SFT,  32'd1,         32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_WR,   SFT,  32'h0000_0002, 32'h0000_0001, 32'h0000_0000, 1'b0},
	'{OP_WAIT, SFT,  32'd1,         32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_WR,   SFT,  32'h0000_0003, 32'h0000_0001, 32'h0000_0000, 1'b0},
	'{OP_RD,   SFT,  32'h0000_0000, 32'h0000_0008, 32'h0000_000f, 1'b0},
	// driver b, second byte lands while busy
	'{OP_WR,   SFTB, 32'h0000_3c01, 32'h0000_0001, 32'h0000_0000, 1'b0},
	'{OP_WR,   SFTB, 32'h0000_ff01, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_WAIT, SFTB, 32'd1,         32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_RD,   SFTB, 32'h0000_0000, 32'h0000_000c, 32'h0000_000f, 1'b0},
	// pwm duty 300
	'{OP_WR,   PWMC, 32'h0000_012c, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_WAIT, PWMC, 32'd3,         32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_RD,   PWMC, 32'h0000_0000, 32'h0000_012c, 32'hffff_ffff, 1'b0},
	// watchdog 600, reloaded once
	'{OP_WR,   WDG,  32'h0000_04b1, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_WAIT, WDG,  32'd1,         32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_WR,   WDG,  32'h0000_04b1, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_WAIT, WDG,  32'd2,         32'h0000_0000, 32'h0000_0000, 1'b0},
	// tach
	'{OP_FAN,  FAN0, 32'h0005_0009, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_RD,   FAN0, 32'h0000_0000, 32'h0000_0009, 32'hffff_ffff, 1'b0},
	'{OP_RD,   FAN1, 32'h0000_0000, 32'h0000_0005, 32'hffff_ffff, 1'b0},
	// timer0 = 3 unmasked, timer1 = 2 masked
	'{OP_WR,   TIME, 32'h000b_000d, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_WAIT, TIME, 32'd4,         32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_RD,   TIME, 32'h0000_0000, 32'h0102_0100, 32'hffff_ffff, 1'b0},
	'{OP_WR,   TIME, 32'h0002_0100, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{OP_RD,   TIME, 32'h0000_0000, 32'h0102_0000, 32'hffff_ffff, 1'b0},
	'{OP_RD,   mm_addr_e'(6'h3f), 32'h0, 32'h0000_0000, 32'hffff_ffff, 1'b0}
};

`endif

/* dv/tb_mm_periph.sv */
`timescale 1ns/1ps

module tb_mm_periph;
	import mm_pkg::*;

	`include "mm_vectors.svh"

	logic        CLK_I;
	logic        RST_I;
	logic        wb_stb;
	logic        wb_we;
	logic [5:0]  wb_adr;
	logic [31:0] wb_dat_i;
	logic        wb_ack;
	logic [31:0] wb_dat_o;
	logic [1:0]  fan_in;
	logic [15:0] gpio_in;
	logic        pwm;
	logic        watch_dog;
	sft_pins_t   sft_a;
	sft_pins_t   sft_b;
	sft_pins_t   pins_now [2];
	logic        time0_int;
	logic        time1_int;
	logic [15:0] gpio_out;
	logic        clk25m_on;

	int          cyc = 0;
	int          rst_cyc = 0;
	int          cycle_limit = 1000000;
	logic [15:0] gpio_in_val;
	logic [15:0] gpio_wr_val;
	// expected and seen shift driver activity, [0] = a
	logic [31:0] exp_bits [2] = '{0, 0};
	int          exp_cnt [2] = '{0, 0};
	int          exp_mr [2] = '{0, 0};
	int          exp_st [2] = '{0, 0};
	logic [31:0] got_bits [2] = '{0, 0};
	int          got_cnt [2] = '{0, 0};
	int          mr_cnt [2] = '{0, 0};
	int          st_cnt [2] = '{0, 0};
	int          mr_len [2] = '{0, 0};
	int          st_len [2] = '{0, 0};
	logic [1:0]  shcp_q = 2'b00;
	logic [1:0]  mr_q = 2'b11;
	logic [1:0]  stcp_q = 2'b00;
	// pwm, watchdog and timer monitors
	logic        pwm_armed = 1'b0;
	logic        pwm_checked = 1'b0;
	int          pwm_from = 0;
	int          pwm_high = 0;
	int          pwm_duty_exp = 0;
	int          wdg_n = 0;
	int          wdg_wr_cyc = 0;
	int          wdg_len = 0;
	int          wdg_pulses = 0;
	logic        wdg_q = 1'b0;
	int          tim_load_cyc = 0;
	int          int0_rises = 0;
	logic        int0_q = 1'b0;

	mm_periph i_mm_periph (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_i  (wb_dat_i),
		.wb_ack    (wb_ack),
		.wb_dat_o  (wb_dat_o),
		.fan_in    (fan_in),
		.gpio_in   (gpio_in),
		.pwm       (pwm),
		.watch_dog (watch_dog),
		.sft_a     (sft_a),
		.sft_b     (sft_b),
		.time0_int (time0_int),
		.time1_int (time1_int),
		.gpio_out  (gpio_out),
		.clk25m_on (clk25m_on)
	);

	assign pins_now[0] = sft_a;
	assign pins_now[1] = sft_b;

	initial begin
		CLK_I = 1'b0;
		forever #5 CLK_I = ~CLK_I;
	end

	// ------------------------------------------------------------
	// reporting and bus helpers
	// ------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
		assert (act === exp) else
			abort_run($sformatf("** Error at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, exp, act));
	endtask

	task automatic bus_access(input logic wr, input mm_addr_e a, input logic [31:0] d,
		output logic [31:0] q);
		@(posedge CLK_I);
		wb_stb   <= 1'b1;
		wb_we    <= wr;
		wb_adr   <= a;
		wb_dat_i <= d;
		do
			@(posedge CLK_I);
		while (wb_ack !== 1'b1);
		q = wb_dat_o; // still valid on the edge that ends ack
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	// updates the expectations that a write implies
	task automatic note_write(input vec_t v, input logic [31:0] wdata);
		int d;
		d = (v.adr == SFTB) ? 1 : 0;
		case (v.adr)
			GPIO: check_eq("gpio_out", 32'(gpio_out), 32'(wdata[15:0]));
			CLKO: check_eq("clk25m_on", 32'(clk25m_on), 32'(wdata[0]));
			SFT, SFTB: begin
				if (v.exp[0]) begin
					case (sft_op_e'(wdata[1:0]))
						SFT_SHIFT: begin
							exp_bits[d] = {exp_bits[d][23:0], wdata[15:8]};
							exp_cnt[d]  = exp_cnt[d] + 8;
						end
						SFT_MR:    exp_mr[d] = exp_mr[d] + 1;
						SFT_STORE: exp_st[d] = exp_st[d] + 1;
						default:   ;
					endcase
				end
			end
			PWMC: begin
				pwm_duty_exp = int'(wdata[PWM_W-1:0]);
				pwm_from     = cyc + 4;
				pwm_armed    = 1'b1;
			end
			WDG: begin
				wdg_n      = int'(wdata[WDG_W:1]);
				wdg_wr_cyc = cyc;
			end
			TIME: if (wdata[0]) tim_load_cyc = cyc;
			default: ;
		endcase
	endtask

	task automatic fan_burst(input int n0, input int n1);
		int k;
		// start just after a window boundary
		while ((cyc - rst_cyc) % TICK_CYCLES != 20)
			@(posedge CLK_I);
		for (k = 0; k < n0 || k < n1; k++) begin
			fan_in <= {k < n1, k < n0};
			repeat (2 + $urandom % 5) @(posedge CLK_I);
			fan_in <= 2'b00; // falling edges here
			repeat (2 + $urandom % 5) @(posedge CLK_I);
		end
		while ((cyc - rst_cyc) % TICK_CYCLES != 10)
			@(posedge CLK_I); // past the latch at window end
	endtask

	task automatic run_row(input vec_t v);
		logic [31:0] wdata;
		logic [31:0] expv;
		logic [31:0] rdata;
		wdata = v.rnd ? {16'h0, gpio_wr_val} : v.data;
		expv  = v.rnd ? {gpio_in_val, gpio_wr_val} : v.exp;
		case (v.op)
			OP_WR: begin
				bus_access(1'b1, v.adr, wdata, rdata);
				note_write(v, wdata);
			end
			OP_RD: begin
				bus_access(1'b0, v.adr, 32'h0, rdata);
				check_eq($sformatf("wb_dat_o at 0x%02h", v.adr), rdata & v.mask,
					expv & v.mask);
			end
			OP_WAIT: repeat (v.data * TICK_CYCLES) @(posedge CLK_I);
			default: fan_burst(int'(v.data[15:0]), int'(v.data[31:16]));
		endcase
	endtask

	function automatic int count_ticks();
		int n;
		n = 0;
		for (int i = 0; i < N_VECS; i++) begin
			if (VECS[i].op == OP_WAIT)
				n = n + int'(VECS[i].data);
			else if (VECS[i].op == OP_FAN)
				n = n + 2; // alignment plus the burst window
		end
		return n;
	endfunction

	// ------------------------------------------------------------
	// cycle count and timeout
	// ------------------------------------------------------------
	always @(posedge CLK_I) begin
		cyc <= cyc + 1;
		assert (cyc < cycle_limit) else
			abort_run($sformatf("run timed out after %0d cycles", cyc));
	end

	// shift driver pins
	always @(posedge CLK_I) begin
		if (!RST_I) begin
			for (int d = 0; d < 2; d++) begin
				if (pins_now[d].shcp && !shcp_q[d]) begin
					got_bits[d] <= {got_bits[d][30:0], pins_now[d].ds};
					got_cnt[d]  <= got_cnt[d] + 1;
				end
				if (!pins_now[d].mr_n) begin
					mr_len[d] <= mr_len[d] + 1;
				end else if (!mr_q[d]) begin
					check_eq($sformatf("sft%0d mr_n low cycles", d), mr_len[d], SFT_PULSE);
					mr_len[d] <= 0;
					mr_cnt[d] <= mr_cnt[d] + 1;
				end
				if (pins_now[d].stcp) begin
					st_len[d] <= st_len[d] + 1;
				end else if (stcp_q[d]) begin
					check_eq($sformatf("sft%0d stcp high cycles", d), st_len[d], SFT_PULSE);
					st_len[d] <= 0;
					st_cnt[d] <= st_cnt[d] + 1;
				end
				shcp_q[d] <= pins_now[d].shcp;
				mr_q[d]   <= pins_now[d].mr_n;
				stcp_q[d] <= pins_now[d].stcp;
			end
		end
	end

	// pwm window, watchdog pulse, interrupts
	always @(posedge CLK_I) begin
		if (!RST_I) begin
			if (pwm_armed && cyc >= pwm_from && !pwm_checked) begin
				if (cyc < pwm_from + 2**PWM_W) begin
					if (pwm)
						pwm_high <= pwm_high + 1;
				end else begin
					check_eq("pwm high cycles", pwm_high, pwm_duty_exp + 1);
					pwm_checked <= 1'b1;
				end
			end
			if (watch_dog)
				wdg_len <= wdg_len + 1;
			if (watch_dog && !wdg_q) begin
				assert ((cyc - wdg_wr_cyc >= wdg_n - 4) && (cyc - wdg_wr_cyc <= wdg_n + 2)) else
					abort_run($sformatf("watch_dog rose %0d cycles after the write, not near %0d",
						cyc - wdg_wr_cyc, wdg_n));
			end
			if (!watch_dog && wdg_q) begin
				check_eq("watch_dog high cycles", wdg_len, 2);
				wdg_len    <= 0;
				wdg_pulses <= wdg_pulses + 1;
			end
			if (time0_int && !int0_q) begin
				assert ((cyc - tim_load_cyc >= 2 * TICK_CYCLES) &&
					(cyc - tim_load_cyc <= 3 * TICK_CYCLES + 4)) else
					abort_run($sformatf("time0_int rose %0d cycles after the load",
						cyc - tim_load_cyc));
				int0_rises <= int0_rises + 1;
			end
			assert (!time1_int) else
				abort_run("time1_int went high although timer1 is masked");
			wdg_q  <= watch_dog;
			int0_q <= time0_int;
		end
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		logic [31:0] rnd_word;
		rnd_word    = $urandom(28256);
		rnd_word    = $urandom;
		gpio_in_val = rnd_word[15:0];
		rnd_word    = $urandom;
		gpio_wr_val = rnd_word[15:0];
		cycle_limit = count_ticks() * TICK_CYCLES + 2000;
		RST_I    = 1'b1;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 6'h0;
		wb_dat_i = 32'h0;
		fan_in   = 2'b00;
		gpio_in  = gpio_in_val;
		repeat (10) @(posedge CLK_I);
		RST_I   <= 1'b0;
		rst_cyc = cyc;
		@(posedge CLK_I);
		check_eq("wb_ack", 32'(wb_ack), 32'h0);
		check_eq("time0_int", 32'(time0_int), 32'h0);
		check_eq("time1_int", 32'(time1_int), 32'h0);
		check_eq("watch_dog", 32'(watch_dog), 32'h0);
		check_eq("sft_a pins", 32'(sft_a), 32'h3); // mr_n and oe_n high
		check_eq("sft_b pins", 32'(sft_b), 32'h3);

		for (int i = 0; i < N_VECS; i++)
			run_row(VECS[i]);
		repeat (4) @(posedge CLK_I);

		for (int d = 0; d < 2; d++) begin
			check_eq($sformatf("sft%0d ds bit count", d), got_cnt[d], exp_cnt[d]);
			check_eq($sformatf("sft%0d ds bits", d), got_bits[d], exp_bits[d]);
			check_eq($sformatf("sft%0d mr_n pulses", d), mr_cnt[d], exp_mr[d]);
			check_eq($sformatf("sft%0d stcp pulses", d), st_cnt[d], exp_st[d]);
		end
		assert (pwm_checked) else
			abort_run("pwm period was never measured");
		check_eq("watch_dog pulses", wdg_pulses, 1);
		check_eq("time0_int rises", int0_rises, 1);
		check_eq("time0_int after clear", 32'(time0_int), 32'h0);
		$display("Verification passed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+dv
logic/mm_pkg.sv
logic/sft_drv.sv
logic/fan_tach.sv
logic/sec_timer.sv
logic/mm_regs.sv
logic/mm_periph.sv
dv/tb_mm_periph.sv

/* Bender.yml */
package:
  name: mm_periph

sources:
  - logic/mm_pkg.sv
  - logic/sft_drv.sv
  - logic/fan_tach.sv
  - logic/sec_timer.sv
  - logic/mm_regs.sv
  - logic/mm_periph.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_mm_periph.sv
